//--- dma_cfg_pkg.sv
// Configuration constants: buffer depth, bus widths, data-memory window, AXI size codes

package dma_cfg_pkg;

   // ********************
   // Command buffer
   localparam int DMA_DEPTH = 4;
   localparam int DMA_PTR_W = $clog2(DMA_DEPTH);

   // ********************
   // Bus widths
   localparam int TAG_W  = 4;   // AXI id
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = DATA_W / 8;

   // ********************
   // Data-memory window
   localparam logic [ADDR_W-1:0] DCCM_BASE       = 32'hF004_0000;
   localparam logic [ADDR_W-1:0] DCCM_SIZE_BYTES = 32'h0001_0000;   // 64 KiB

   // AXI size codes
   localparam logic [2:0] SZ_BYTE  = 3'd0;
   localparam logic [2:0] SZ_HALF  = 3'd1;
   localparam logic [2:0] SZ_WORD  = 3'd2;
   localparam logic [2:0] SZ_DWORD = 3'd3;

endpackage

//--- dma_bus_pkg.sv
// Bus payload structs, merged command, memory request/response, response codes, check result

package dma_bus_pkg;

   import dma_cfg_pkg::*;

   // AXI response codes
   typedef logic [1:0] resp_t;
   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;   // Misalignment or ECC error
   localparam resp_t RESP_DECERR = 2'b11;   // Outside the window

   // ********************
   // AXI channel beats
   typedef struct packed {
      logic [TAG_W-1:0]  id;
      logic [ADDR_W-1:0] addr;
      logic [2:0]        size;
   } axi_aw_t;                              // Also the AR payload

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [TAG_W-1:0] id;
      resp_t            resp;
   } axi_b_t;

   typedef struct packed {
      logic [TAG_W-1:0]  id;
      resp_t             resp;
      logic [DATA_W-1:0] data;
   } axi_r_t;

   // ********************
   // Merged command as stored in the buffer
   typedef struct packed {
      logic              write;
      logic [ADDR_W-1:0] addr;
      logic [2:0]        size;
      logic [STRB_W-1:0] strb;
      logic [DATA_W-1:0] wdata;
      logic [TAG_W-1:0]  tag;
   } bus_cmd_t;

   // Memory port, tag is the buffer index
   typedef struct packed {
      logic [DMA_PTR_W-1:0] tag;
      logic [ADDR_W-1:0]    addr;
      logic [2:0]           size;
      logic                 write;
      logic [DATA_W-1:0]    wdata;
   } mem_req_t;

   typedef struct packed {
      logic [DMA_PTR_W-1:0] tag;
      logic [DATA_W-1:0]    rdata;
      logic                 ecc_error;
   } mem_rsp_t;

   typedef enum logic [1:0] {CHK_OK, CHK_ADDR, CHK_ALIGN} chk_err_t;

endpackage

//--- dma_chan_buf.sv
// One-entry holding buffer for a single AXI channel beat

`timescale 1ns/1ps

module dma_chan_buf
   import dma_bus_pkg::*;
#(
   parameter type payload_t = axi_aw_t
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   input  logic     release_buf,   // Consumer takes the held beat
   output logic     buf_valid,
   output payload_t buf_data
);

   logic accept;

   // Free now, or freed by the release in this cycle
   assign in_ready = ~buf_valid | release_buf;
   assign accept   = in_valid & in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         buf_valid <= 1'b0;
      end else if (accept) begin
         buf_valid <= 1'b1;         // A new beat wins over the release
      end else if (release_buf) begin
         buf_valid <= 1'b0;
      end
   end

   // Payload only moves on acceptance
   always_ff @(posedge clk) begin
      if (accept) begin
         buf_data <= in_data;
      end
   end

endmodule

//--- dma_bus_arb.sv
// Merges the write and read channel beats into one command, alternating priority

`timescale 1ns/1ps

module dma_bus_arb
   import dma_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     wr_addr_valid,
   input  axi_aw_t  wr_addr,
   input  logic     wr_data_valid,
   input  axi_w_t   wr_data,
   input  logic     rd_addr_valid,
   input  axi_aw_t  rd_addr,
   input  logic     cmd_ready,
   output logic     cmd_valid,
   output bus_cmd_t cmd,
   output logic     wr_release,
   output logic     rd_release
);

   logic wr_ok;      // Both AW and W beats held
   logic sel_wr;
   logic wr_prio;    // 1 gives the write side priority
   logic cmd_sent;

   assign wr_ok     = wr_addr_valid & wr_data_valid;
   assign sel_wr    = (wr_ok & rd_addr_valid) ? wr_prio : wr_ok;
   assign cmd_valid = wr_ok | rd_addr_valid;
   assign cmd_sent  = cmd_valid & cmd_ready;

   assign wr_release = cmd_sent & sel_wr;
   assign rd_release = cmd_sent & ~sel_wr;

   // Command fields
   always_comb begin
      cmd.write = sel_wr;
      cmd.addr  = sel_wr ? wr_addr.addr : rd_addr.addr;
      cmd.size  = sel_wr ? wr_addr.size : rd_addr.size;
      cmd.tag   = sel_wr ? wr_addr.id : rd_addr.id;
      cmd.strb  = wr_data.strb;    // Don't care for reads
      cmd.wdata = wr_data.data;
   end

   // ********************
   // Priority flips on every sent command, write goes first out of reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_prio <= 1'b1;
      end else if (cmd_sent) begin
         wr_prio <= ~wr_prio;
      end
   end

endmodule

//--- dma_access_check.sv
// Window and alignment check of the head command, memory address and size fix-up

`timescale 1ns/1ps

module dma_access_check
   import dma_cfg_pkg::*;
   import dma_bus_pkg::*;
(
   input  bus_cmd_t          head_cmd,
   output chk_err_t          chk_err,
   output logic [ADDR_W-1:0] mem_addr,
   output logic [2:0]        mem_size
);

   logic [ADDR_W-1:0] offset;
   logic              in_window;
   logic              misaligned;
   logic              bad_write;
   logic              upper_only;   // Strobes F0
   logic              lower_only;   // Strobes 0F
   logic [STRB_W-1:0] strb;
   logic [2:0]        size;
   logic [ADDR_W-1:0] addr;

   assign strb = head_cmd.strb;
   assign size = head_cmd.size;
   assign addr = head_cmd.addr;

   // Unsigned offset also catches addresses below the base
   assign offset    = addr - DCCM_BASE;
   assign in_window = offset < DCCM_SIZE_BYTES;

   assign upper_only = strb == 8'hF0;
   assign lower_only = strb == 8'h0F;

   // ********************
   // Alignment to the access size
   assign misaligned = ((size == SZ_HALF) & addr[0]) |
                       ((size == SZ_WORD) & (|addr[1:0])) |
                       ((size == SZ_DWORD) & (|addr[2:0]));

   // Write rules: word or larger, strobes covering whole words
   always_comb begin
      bad_write = 1'b0;
      if (head_cmd.write) begin
         if (size < SZ_WORD) begin
            bad_write = 1'b1;
         end else if (size == SZ_WORD) begin
            // Nibble picked by address bit 2
            bad_write = addr[2] ? (strb[7:4] != 4'hF) : (strb[3:0] != 4'hF);
         end else if (size == SZ_DWORD) begin
            bad_write = ~(lower_only | upper_only | (strb == 8'hFF));
         end
      end
   end

   always_comb begin
      if (!in_window) begin
         chk_err = CHK_ADDR;
      end else if (misaligned | bad_write) begin
         chk_err = CHK_ALIGN;
      end else begin
         chk_err = CHK_OK;
      end
   end

   // Half-filled double-word writes go out as one word
   assign mem_addr = (head_cmd.write & upper_only) ? {addr[ADDR_W-1:3], 1'b1, addr[1:0]} : addr;
   assign mem_size = (head_cmd.write & (upper_only | lower_only)) ? SZ_WORD : size;

endmodule

//--- dma_cmd_fifo.sv
// Circular command buffer with issue to memory, tagged read return and in-order AXI response

`timescale 1ns/1ps

module dma_cmd_fifo
   import dma_cfg_pkg::*;
   import dma_bus_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cmd_valid,
   input  bus_cmd_t          cmd,
   output logic              cmd_ready,
   output bus_cmd_t          head_cmd,
   input  chk_err_t          chk_err,
   input  logic [ADDR_W-1:0] mem_addr,
   input  logic [2:0]        mem_size,
   output logic              mem_req_valid,
   output mem_req_t          mem_req,
   input  logic              mem_ready,
   input  logic              mem_rsp_valid,
   input  mem_rsp_t          mem_rsp,
   output logic              b_valid,
   output axi_b_t            b,
   input  logic              b_ready,
   output logic              r_valid,
   output axi_r_t            r,
   input  logic              r_ready,
   output logic              busy
);

   // Entry status
   logic [DMA_DEPTH-1:0] ent_valid;
   logic [DMA_DEPTH-1:0] ent_pend;    // Read issued, data outstanding
   logic [DMA_DEPTH-1:0] ent_done;
   resp_t                ent_err  [DMA_DEPTH];
   logic [DATA_W-1:0]    ent_data [DMA_DEPTH];
   bus_cmd_t             ent_cmd  [DMA_DEPTH];

   logic [DMA_PTR_W-1:0] wr_ptr, iss_ptr, rsp_ptr;

   logic      cmd_sent;
   logic      head_live, head_err, issue;
   logic      rsp_valid, rsp_sent;
   resp_t     head_resp;
   logic [DMA_DEPTH-1:0] cmd_en, iss_en, err_en, ret_en, clr_en;

   function automatic logic [DMA_PTR_W-1:0] ptr_inc(input logic [DMA_PTR_W-1:0] p);
      return (p == DMA_PTR_W'(DMA_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // In-order buffer: full exactly when the slot at the write pointer is taken
   assign cmd_ready = ~ent_valid[wr_ptr];
   assign cmd_sent  = cmd_valid & cmd_ready;
   assign busy      = |ent_valid;

   // ********************
   // Issue side
   assign head_cmd  = ent_cmd[iss_ptr];
   assign head_live = ent_valid[iss_ptr] & ~ent_pend[iss_ptr] & ~ent_done[iss_ptr];
   assign head_err  = head_live & (chk_err != CHK_OK);
   assign head_resp = (chk_err == CHK_ADDR) ? RESP_DECERR : RESP_SLVERR;

   assign mem_req_valid = head_live & (chk_err == CHK_OK);
   assign issue         = mem_req_valid & mem_ready;

   always_comb begin
      mem_req.tag   = iss_ptr;
      mem_req.addr  = mem_addr;
      mem_req.size  = mem_size;
      mem_req.write = head_cmd.write;
      mem_req.wdata = head_cmd.wdata;
   end

   // ********************
   // Response side, strictly from the response pointer
   assign rsp_valid = ent_valid[rsp_ptr] & ent_done[rsp_ptr];
   assign b_valid   = rsp_valid & ent_cmd[rsp_ptr].write;
   assign r_valid   = rsp_valid & ~ent_cmd[rsp_ptr].write;
   assign rsp_sent  = (b_valid & b_ready) | (r_valid & r_ready);

   always_comb begin
      b.id   = ent_cmd[rsp_ptr].tag;
      b.resp = ent_err[rsp_ptr];
      r.id   = ent_cmd[rsp_ptr].tag;
      r.resp = ent_err[rsp_ptr];
      r.data = ent_data[rsp_ptr];
   end

   // Pointers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         iss_ptr <= '0;
         rsp_ptr <= '0;
      end else begin
         if (cmd_sent)         wr_ptr  <= ptr_inc(wr_ptr);
         if (issue | head_err) iss_ptr <= ptr_inc(iss_ptr);
         if (rsp_sent)         rsp_ptr <= ptr_inc(rsp_ptr);
      end
   end

   // ********************
   // Per-entry state
   for (genvar i = 0; i < DMA_DEPTH; i++) begin : g_ent
      assign cmd_en[i] = cmd_sent & (wr_ptr == DMA_PTR_W'(i));
      assign iss_en[i] = issue & (iss_ptr == DMA_PTR_W'(i));
      assign err_en[i] = head_err & (iss_ptr == DMA_PTR_W'(i));
      assign ret_en[i] = mem_rsp_valid & ent_pend[i] & (mem_rsp.tag == DMA_PTR_W'(i));
      assign clr_en[i] = rsp_sent & (rsp_ptr == DMA_PTR_W'(i));

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            ent_valid[i] <= 1'b0;
            ent_pend[i]  <= 1'b0;
            ent_done[i]  <= 1'b0;
            ent_err[i]   <= RESP_OKAY;
         end else if (clr_en[i]) begin
            ent_valid[i] <= 1'b0;
            ent_pend[i]  <= 1'b0;
            ent_done[i]  <= 1'b0;
            ent_err[i]   <= RESP_OKAY;
         end else begin
            if (cmd_en[i]) ent_valid[i] <= 1'b1;
            if (iss_en[i]) begin
               ent_pend[i] <= ~ent_cmd[i].write;   // Writes finish when taken
               ent_done[i] <= ent_cmd[i].write;
            end
            if (err_en[i]) begin
               ent_done[i] <= 1'b1;
               ent_err[i]  <= head_resp;
            end
            if (ret_en[i]) begin
               ent_pend[i] <= 1'b0;
               ent_done[i] <= 1'b1;
               ent_err[i]  <= mem_rsp.ecc_error ? RESP_SLVERR : RESP_OKAY;
            end
         end
      end

      // Command and response data
      always_ff @(posedge clk) begin
         if (cmd_en[i]) ent_cmd[i] <= cmd;
         if (err_en[i]) begin
            ent_data[i] <= DATA_W'(ent_cmd[i].addr);   // Offending address
         end else if (ret_en[i]) begin
            ent_data[i] <= mem_rsp.rdata;
         end
      end
   end

endmodule

//--- dma_ctrl.sv
// DMA slave controller top: channel buffers, arbiter, command buffer and access check

`timescale 1ns/1ps

module dma_ctrl
   import dma_cfg_pkg::*;
   import dma_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   // AXI write
   input  logic     aw_valid,
   output logic     aw_ready,
   input  axi_aw_t  aw,
   input  logic     w_valid,
   output logic     w_ready,
   input  axi_w_t   w,
   output logic     b_valid,
   input  logic     b_ready,
   output axi_b_t   b,
   // AXI read
   input  logic     ar_valid,
   output logic     ar_ready,
   input  axi_aw_t  ar,
   output logic     r_valid,
   input  logic     r_ready,
   output axi_r_t   r,
   // Memory port
   output logic     mem_req_valid,
   output mem_req_t mem_req,
   input  logic     mem_ready,
   input  logic     mem_rsp_valid,
   input  mem_rsp_t mem_rsp,
   output logic     dma_active
);

   logic              aw_buf_valid, w_buf_valid, ar_buf_valid;
   axi_aw_t           aw_buf, ar_buf;
   axi_w_t            w_buf;
   logic              wr_release, rd_release;
   logic              cmd_valid, cmd_ready;
   bus_cmd_t          cmd, head_cmd;
   chk_err_t          chk_err;
   logic [ADDR_W-1:0] mem_addr;
   logic [2:0]        mem_size;
   logic              busy;

   // ********************
   // Channel buffers, AW and W are released together
   dma_chan_buf #(.payload_t(axi_aw_t)) u_aw_buf (
      .clk, .rst_n, .in_valid(aw_valid), .in_data(aw), .release_buf(wr_release),
      .in_ready(aw_ready), .buf_valid(aw_buf_valid), .buf_data(aw_buf));

   dma_chan_buf #(.payload_t(axi_w_t)) u_w_buf (
      .clk, .rst_n, .in_valid(w_valid), .in_data(w), .release_buf(wr_release),
      .in_ready(w_ready), .buf_valid(w_buf_valid), .buf_data(w_buf));

   dma_chan_buf #(.payload_t(axi_aw_t)) u_ar_buf (
      .clk, .rst_n, .in_valid(ar_valid), .in_data(ar), .release_buf(rd_release),
      .in_ready(ar_ready), .buf_valid(ar_buf_valid), .buf_data(ar_buf));

   dma_bus_arb u_arb (
      .clk, .rst_n,
      .wr_addr_valid(aw_buf_valid), .wr_addr(aw_buf),
      .wr_data_valid(w_buf_valid), .wr_data(w_buf),
      .rd_addr_valid(ar_buf_valid), .rd_addr(ar_buf),
      .cmd_ready, .cmd_valid, .cmd, .wr_release, .rd_release);

   dma_access_check u_check (.head_cmd, .chk_err, .mem_addr, .mem_size);

   dma_cmd_fifo u_fifo (
      .clk, .rst_n, .cmd_valid, .cmd, .cmd_ready, .head_cmd,
      .chk_err, .mem_addr, .mem_size,
      .mem_req_valid, .mem_req, .mem_ready, .mem_rsp_valid, .mem_rsp,
      .b_valid, .b, .b_ready, .r_valid, .r, .r_ready, .busy);

   assign dma_active = aw_buf_valid | w_buf_valid | ar_buf_valid | busy;   // Anything held

endmodule

//--- tb_dma_model.svh
// Testbench model: xorshift generators, memory images, access rules, expected-response table, compares

localparam int WIN_BYTES = int'(DCCM_SIZE_BYTES);
localparam int MAX_OUT   = DMA_DEPTH + 2;     // Outstanding transactions
localparam int N_IDS     = 2 ** TAG_W;

logic [63:0] stim_seed = 64'd84;
logic [63:0] bus_seed  = 64'd84 ^ 64'h9E37_79B9_7F4A_7C15;   // Second stream for the bus side

function automatic logic [63:0] xorshift(input logic [63:0] s);
   logic [63:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 7);
   x = x ^ (x << 17);
   return x;
endfunction

function automatic logic [63:0] stim_rand();
   stim_seed = xorshift(stim_seed);
   return stim_seed;
endfunction

function automatic logic [63:0] bus_rand();
   bus_seed = xorshift(bus_seed);
   return bus_seed;
endfunction

// ********************
// Memory images: model_mem takes the DUT's requests, ref_mem follows the AXI rules
logic [7:0] model_mem [WIN_BYTES];
logic [7:0] ref_mem   [WIN_BYTES];

function automatic int win_off(input logic [ADDR_W-1:0] a);
   return int'(a - DCCM_BASE);
endfunction

task automatic init_memories();
   logic [ADDR_W-1:0] a;
   for (int i = 0; i < WIN_BYTES; i++) begin
      a = DCCM_BASE + ADDR_W'(i);
      model_mem[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
      ref_mem[i]   = model_mem[i];
   end
endtask

// Write lanes follow the request size and address
task automatic model_write(input mem_req_t req);
   int n;
   int lo;
   n  = 1 << req.size;
   lo = win_off(req.addr) & ~(n - 1);
   for (int k = 0; k < n; k++) model_mem[lo + k] = req.wdata[8 * ((lo + k) % 8) +: 8];
endtask

function automatic logic [DATA_W-1:0] model_dword(input logic [ADDR_W-1:0] a);
   logic [DATA_W-1:0] d;
   for (int k = 0; k < 8; k++) d[8 * k +: 8] = model_mem[(win_off(a) & ~7) + k];
   return d;
endfunction

function automatic logic [DATA_W-1:0] ref_dword(input logic [ADDR_W-1:0] a);
   logic [DATA_W-1:0] d;
   for (int k = 0; k < 8; k++) d[8 * k +: 8] = ref_mem[(win_off(a) & ~7) + k];
   return d;
endfunction

// Strobed bytes inside the access range land in the reference image
task automatic ref_write(input logic [ADDR_W-1:0] a, input logic [2:0] size,
                         input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] data);
   int n;
   int lo;
   int base;
   n    = 1 << size;
   lo   = win_off(a) & ~(n - 1);
   base = win_off(a) & ~7;
   for (int k = 0; k < 8; k++) begin
      if (strb[k] && base + k >= lo && base + k < lo + n) ref_mem[base + k] = data[8 * k +: 8];
   end
endtask

// Response code from the window and alignment rules
function automatic resp_t rule_resp(input logic wr, input logic [ADDR_W-1:0] a,
                                    input logic [2:0] size, input logic [STRB_W-1:0] strb);
   logic bad;
   if (a - DCCM_BASE >= DCCM_SIZE_BYTES) return RESP_DECERR;
   bad = (a & ((32'd1 << size) - 1)) != 0;
   if (wr && size < SZ_WORD) bad = 1'b1;
   if (wr && size == SZ_WORD && strb[4 * a[2] +: 4] != 4'hF) bad = 1'b1;
   if (wr && size == SZ_DWORD && !(strb inside {8'h0F, 8'hF0, 8'hFF})) bad = 1'b1;
   return bad ? RESP_SLVERR : RESP_OKAY;
endfunction

// ********************
// Expected responses by id
logic             exp_busy [N_IDS];
logic             exp_wr   [N_IDS];
axi_b_t           exp_b    [N_IDS];
axi_r_t           exp_r    [N_IDS];
int               outstanding = 0;
int               answered    = 0;
logic [TAG_W-1:0] next_id     = '0;

task automatic record_expect(input logic wr, input logic [ADDR_W-1:0] a, input logic [2:0] size,
                             input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] data,
                             output logic [TAG_W-1:0] id);
   resp_t resp;
   while (exp_busy[next_id]) next_id++;
   id      = next_id;
   next_id = next_id + 1'b1;
   resp    = rule_resp(wr, a, size, strb);
   exp_busy[id]   = 1'b1;
   exp_wr[id]     = wr;
   exp_b[id].id   = id;
   exp_b[id].resp = resp;
   exp_r[id].id   = id;
   if (resp != RESP_OKAY) begin
      exp_r[id].resp = resp;
      exp_r[id].data = DATA_W'(a);          // Offending address
   end else if (!wr) begin
      exp_r[id].resp = (a[5:3] == 3'b111) ? RESP_SLVERR : RESP_OKAY;   // ECC hit
      exp_r[id].data = ref_dword(a);
   end else begin
      ref_write(a, size, strb, data);
   end
   outstanding++;
endtask

task automatic retire(input logic [TAG_W-1:0] id);
   exp_busy[id] = 1'b0;
   outstanding--;
   answered++;
endtask

// ********************
// Compares
task automatic compare_b(input axi_b_t got);
   if (!exp_busy[got.id] || !exp_wr[got.id]) begin
      report_failure($sformatf("B response with id %0d, but no write with that id is open", got.id));
   end else if (got !== exp_b[got.id]) begin
      report_failure($sformatf("Mismatch at %0t: b got %h, expected %h",
                               $time, got, exp_b[got.id]));
   end else begin
      retire(got.id);
   end
endtask

task automatic compare_r(input axi_r_t got);
   if (!exp_busy[got.id] || exp_wr[got.id]) begin
      report_failure($sformatf("R response with id %0d, but no read with that id is open", got.id));
   end else if (got !== exp_r[got.id]) begin
      report_failure($sformatf("Mismatch at %0t: r got %h, expected %h",
                               $time, got, exp_r[got.id]));
   end else begin
      retire(got.id);
   end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp));
   end
endtask

task automatic compare_byte(input logic [ADDR_W-1:0] a, input logic [7:0] got, input logic [7:0] exp);
   if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: memory byte %h got %h, expected %h",
                               $time, a, got, exp));
   end
endtask

//--- tb_dma_ctrl.sv
// Testbench top: clock, reset, stimulus phases, memory responder, response monitor, timeout, verdict

`timescale 1ns/1ps

module tb_dma_ctrl
   import dma_cfg_pkg::*;
   import dma_bus_pkg::*;
();

   localparam int N_WRRD  = 8;        // Writes, each read back
   localparam int N_DEC   = 8;
   localparam int N_SLV   = 8;
   localparam int N_ECC   = 4;
   localparam int N_RAND  = 120;
   localparam int N_TXN   = 2 * N_WRRD + N_DEC + N_SLV + N_ECC + N_RAND;
   localparam int CYCLE_LIMIT = 200 * N_TXN + 1000;
   localparam logic [ADDR_W-1:0] WR_REGION = DCCM_BASE;                  // Random writes
   localparam logic [ADDR_W-1:0] RD_REGION = DCCM_BASE + 32'h0000_8000;  // Reads only

   logic     clk = 1'b0;
   logic     rst_n;
   logic     aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
   logic     b_valid, b_ready, r_valid, r_ready;
   axi_aw_t  aw, ar;
   axi_w_t   w;
   axi_b_t   b;
   axi_r_t   r;
   logic     mem_req_valid, mem_ready, mem_rsp_valid, dma_active;
   mem_req_t mem_req;
   mem_rsp_t mem_rsp;
   int       cycles = 0;

   `include "tb_dma_model.svh"

   dma_ctrl dut (.*);

   always #50 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) report_failure($sformatf("Run hung, no finish after %0d cycles", cycles));
   end

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // ********************
   // Memory responder and response back-pressure
   mem_rsp_t rsp_q [$];
   int       delay_q [$];

   task automatic memory_take(input mem_req_t req);
      mem_rsp_t rsp;
      if (req.addr - DCCM_BASE >= DCCM_SIZE_BYTES) begin
         report_failure($sformatf("Memory request to %h lies outside the data-memory window", req.addr));
      end else if (req.write) begin
         model_write(req);
      end else begin
         rsp.tag       = req.tag;
         rsp.rdata     = model_dword(req.addr);
         rsp.ecc_error = req.addr[5:3] == 3'b111;   // One double word in eight
         rsp_q.push_back(rsp);
         delay_q.push_back(1 + int'(bus_rand() % 5));
      end
   endtask

   task automatic memory_return();
      int pick;
      pick = -1;
      foreach (delay_q[i]) begin
         delay_q[i]--;
         if (delay_q[i] <= 0 && pick < 0) pick = i;
      end
      mem_rsp_valid = 1'b0;
      if (pick >= 0) begin
         mem_rsp_valid = 1'b1;
         mem_rsp       = rsp_q[pick];
         rsp_q.delete(pick);
         delay_q.delete(pick);
      end
   endtask

   always begin : mem_side
      logic     take;
      mem_req_t req;
      @(negedge clk);
      take = mem_req_valid && mem_ready;
      req  = mem_req;
      next_cycle();
      if (take) memory_take(req);
      memory_return();
      mem_ready = (bus_rand() % 4) != 0;
      b_ready   = (bus_rand() % 4) != 0;
      r_ready   = (bus_rand() % 4) != 0;
   end

   always @(negedge clk) begin   // Responses
      if (rst_n && b_valid && b_ready) compare_b(b);
      if (rst_n && r_valid && r_ready) compare_r(r);
   end

   // ********************
   // Stimulus
   task automatic send_txn(input logic wr, input logic [ADDR_W-1:0] a, input logic [2:0] size,
                           input logic [STRB_W-1:0] strb, input logic [DATA_W-1:0] data);
      logic [TAG_W-1:0] id;
      logic             a_done;
      logic             d_done;
      while (outstanding >= MAX_OUT) next_cycle();
      record_expect(wr, a, size, strb, data, id);
      a_done = 1'b0;
      d_done = !wr;                          // Reads have no data beat
      if (wr) begin
         aw_valid = 1'b1;
         aw       = {id, a, size};
         w_valid  = 1'b1;
         w        = {data, strb};
      end else begin
         ar_valid = 1'b1;
         ar       = {id, a, size};
      end
      while (!(a_done && d_done)) begin
         @(negedge clk);
         if ((aw_valid && aw_ready) || (ar_valid && ar_ready)) a_done = 1'b1;
         if (w_valid && w_ready) d_done = 1'b1;
         next_cycle();
         if (a_done) aw_valid = 1'b0;
         if (a_done) ar_valid = 1'b0;
         if (d_done) w_valid = 1'b0;
      end
   endtask

   task automatic wait_idle();
      while (outstanding != 0) next_cycle();
   endtask

   task automatic check_idle_flags();
      @(negedge clk);
      compare_bit("dma_active", dma_active, 1'b0);
      compare_bit("b_valid", b_valid, 1'b0);
      compare_bit("r_valid", r_valid, 1'b0);
      compare_bit("mem_req_valid", mem_req_valid, 1'b0);
      compare_bit("aw_ready", aw_ready, 1'b1);
      compare_bit("w_ready", w_ready, 1'b1);
      compare_bit("ar_ready", ar_ready, 1'b1);
      next_cycle();
   endtask

   task automatic send_random();
      logic [63:0]       rv;
      logic              wr;
      logic [2:0]        size;
      logic [ADDR_W-1:0] a;
      logic [STRB_W-1:0] strb;
      rv   = stim_rand();
      wr   = rv[0];
      size = rv[5:4];
      if (wr && rv[3:1] != 3'd0) size = {1'b1, rv[4]};   // Mostly word or double word
      a = (wr ? WR_REGION : RD_REGION) + {rv[15:11], 3'b000};
      if (size == SZ_WORD) a[2] = rv[22];
      if (rv[18:16] == 3'd0) a[2:0] = rv[21:19];         // Occasionally misaligned
      if (rv[26:23] == 4'd0) a = DCCM_BASE + DCCM_SIZE_BYTES + {rv[47:35], 3'b000};
      case (rv[29:27])
         3'd0:    strb = rv[63:56];
         3'd1:    strb = 8'h0F;
         3'd2:    strb = 8'hF0;
         default: strb = 8'hFF;
      endcase
      send_txn(wr, a, size, strb, stim_rand());
   endtask

   initial begin
      logic [ADDR_W-1:0] a;
      rst_n = 1'b0;
      {aw_valid, w_valid, ar_valid, b_ready, r_ready, mem_ready, mem_rsp_valid} = '0;
      aw = '0;
      w  = '0;
      ar = '0;
      mem_rsp = '0;
      init_memories();
      for (int i = 0; i < N_IDS; i++) exp_busy[i] = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_idle_flags();

      // Legal writes, then read back
      for (int i = 0; i < N_WRRD; i++) begin
         a = RD_REGION + ADDR_W'(8 * i);
         case (stim_rand() % 4)
            0:       send_txn(1'b1, a, SZ_DWORD, 8'hFF, stim_rand());
            1:       send_txn(1'b1, a, SZ_DWORD, 8'h0F, stim_rand());
            2:       send_txn(1'b1, a, SZ_DWORD, 8'hF0, stim_rand());
            default: send_txn(1'b1, a + 32'd4, SZ_WORD, 8'hFF, stim_rand());
         endcase
      end
      wait_idle();
      for (int i = 0; i < N_WRRD; i++) send_txn(1'b0, RD_REGION + ADDR_W'(8 * i), SZ_DWORD, '0, '0);
      wait_idle();

      // Outside the window, above and below
      for (int i = 0; i < N_DEC; i++) begin
         a = (i % 2) ? DCCM_BASE - 32'd8 * ADDR_W'(1 + stim_rand() % 64)
                     : DCCM_BASE + DCCM_SIZE_BYTES + 32'd8 * ADDR_W'(stim_rand() % 64);
         send_txn(i < N_DEC / 2, a, SZ_DWORD, 8'hFF, stim_rand());
      end
      wait_idle();

      // Misaligned, sub-word and bad strobes
      a = RD_REGION + 32'h100;
      send_txn(1'b1, a, SZ_BYTE, 8'h01, stim_rand());
      send_txn(1'b1, a, SZ_HALF, 8'h03, stim_rand());
      send_txn(1'b1, a, SZ_WORD, 8'hF0, stim_rand());
      send_txn(1'b1, a, SZ_DWORD, 8'h33, stim_rand());
      send_txn(1'b1, a + 32'd4, SZ_DWORD, 8'hFF, stim_rand());
      send_txn(1'b0, a + 32'd2, SZ_WORD, '0, '0);
      send_txn(1'b0, a + 32'd4, SZ_DWORD, '0, '0);
      send_txn(1'b0, a + 32'd1, SZ_HALF, '0, '0);
      wait_idle();

      // Reads that meet an ECC error
      for (int i = 0; i < N_ECC; i++) begin
         send_txn(1'b0, RD_REGION + 32'h38 + ADDR_W'(64 * i), (i % 2) ? SZ_WORD : SZ_DWORD, '0, '0);
      end
      wait_idle();

      for (int i = 0; i < N_RAND; i++) send_random();
      wait_idle();
      next_cycle();
      check_idle_flags();
      for (int i = 0; i < WIN_BYTES; i++) compare_byte(DCCM_BASE + ADDR_W'(i), model_mem[i], ref_mem[i]);

      if (answered != N_TXN) begin
         report_failure($sformatf("Only %0d of %0d transactions were answered", answered, N_TXN));
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

//--- dma_ctrl.f
+incdir+.
dma_cfg_pkg.sv
dma_bus_pkg.sv
dma_chan_buf.sv
dma_bus_arb.sv
dma_access_check.sv
dma_cmd_fifo.sv
dma_ctrl.sv
tb_dma_ctrl.sv
